// File: Bender.yml
package:
  name: icache_fill

sources:
  - files:
      - design/fill_bus_pkg.sv
      - design/icache_pkg.sv
      - design/icache_req_generator.sv
      - design/fill_req_fifo.sv
      - design/fill_mem_responder.sv
      - design/icache_fill_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_icache_fill.sv

// File: build.f
design/fill_bus_pkg.sv
design/icache_pkg.sv
design/icache_req_generator.sv
design/fill_req_fifo.sv
design/fill_mem_responder.sv
design/icache_fill_top.sv
dv/tb_clk_gen.sv
dv/tb_icache_fill.sv

// File: design/fill_bus_pkg.sv
// Fill bus types for transaction ids, beat data and burst codes
package fill_bus_pkg;

	// ==============================
	// Transaction id
	// ==============================

	// Upper nibble holds the core number and a zero bit
	// The low three bits carry the rolling per-beat counter
	typedef logic [7:0] tranid_t;

	// Width of the rolling counter inside a transaction id
	localparam int unsigned TID_CNT_BITS = 3;

	// ==============================
	// Beat payload
	// ==============================

	// One beat of fill data is four 32-bit words
	typedef logic [127:0] data_t;

	// ==============================
	// Burst code
	// ==============================

	// CLASSIC marks an idle bus with no beat in flight
	// FIXED means more beats of the same line follow
	// EOB flags the last beat of the line
	typedef enum logic [1:0] {
		CLASSIC = 2'b00,
		FIXED   = 2'b01,
		EOB     = 2'b11
	} burst_e;

endpackage

// File: design/fill_mem_responder.sv
// Backing store that serves buffered fill beats and registers the responses
module fill_mem_responder #(
	parameter int MEM_LINES = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  head_valid,
	input  fill_bus_pkg::tranid_t head_tid,
	input  icache_pkg::address_t  head_adr,
	input  fill_bus_pkg::burst_e  head_burst,
	input  logic                  fill_hold,
	input  logic                  mem_we,
	input  logic [$clog2(MEM_LINES*icache_pkg::BEATS_PER_LINE)-1:0] mem_idx,
	input  fill_bus_pkg::data_t   mem_wdata,
	output logic                  pop,
	output logic                  rsp_valid,
	output fill_bus_pkg::tranid_t rsp_tid,
	output icache_pkg::address_t  rsp_adr,
	output fill_bus_pkg::data_t   rsp_data,
	output logic                  rsp_last
);

	import fill_bus_pkg::*;
	import icache_pkg::*;

	// ==============================
	// Store geometry
	// ==============================

	localparam int MEM_BEATS = MEM_LINES * BEATS_PER_LINE;
	localparam int IDX_W     = $clog2(MEM_BEATS);
	// Address bits below this one select a byte inside a beat
	localparam int OFS_W     = $clog2(BEAT_BYTES);

	// One entry per beat of every line
	data_t mem [MEM_BEATS];

	logic [IDX_W-1:0] rd_idx;

	// Beat number above the byte offset wraps onto the store size
	assign rd_idx = head_adr[OFS_W +: IDX_W];

	// Take the head whenever the consumer is not held off
	assign pop = head_valid && !fill_hold;

	// ==============================
	// Storage and response payload
	// ==============================

	always_ff @(posedge clk) begin
		// Preload port with no handshake
		if (mem_we)
			mem[mem_idx] <= mem_wdata;
		// Response fields follow the popped entry
		if (pop) begin
			rsp_data <= mem[rd_idx];
			rsp_tid  <= head_tid;
			rsp_adr  <= head_adr;
			rsp_last <= (head_burst == EOB);
		end
	end

	// Response strobe lags the pop by one cycle
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= pop;
	end

endmodule

// File: design/fill_req_fifo.sv
// Fill request buffer that holds beats in order and returns a credit per pop
module fill_req_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req_valid,
	input  fill_bus_pkg::tranid_t req_tid,
	input  icache_pkg::address_t  req_adr,
	input  fill_bus_pkg::burst_e  req_burst,
	input  logic                  pop,
	output logic                  head_valid,
	output fill_bus_pkg::tranid_t head_tid,
	output icache_pkg::address_t  head_adr,
	output fill_bus_pkg::burst_e  head_burst,
	output logic                  credit_ret
);

	import fill_bus_pkg::*;
	import icache_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// Entry storage split by field
	tranid_t  tid_mem   [FIFO_DEPTH];
	address_t adr_mem   [FIFO_DEPTH];
	burst_e   burst_mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;

	// Pointers wrap at the depth so non power of two sizes work too
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Oldest entry is always presented at the head
	assign head_valid = (count != '0);
	assign head_tid   = tid_mem[rd_ptr];
	assign head_adr   = adr_mem[rd_ptr];
	assign head_burst = burst_mem[rd_ptr];

	// A pop on an empty buffer is ignored
	assign do_pop     = pop && head_valid;

	// Every beat handed on frees a slot for the generator
	assign credit_ret = do_pop;

	// The generator never pushes without a credit so no full check is needed
	always_ff @(posedge clk) begin
		if (req_valid) begin
			tid_mem[wr_ptr]   <= req_tid;
			adr_mem[wr_ptr]   <= req_adr;
			burst_mem[wr_ptr] <= req_burst;
		end
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (req_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			// Push and pop together leave the occupancy alone
			case ({req_valid, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: design/icache_fill_top.sv
// Instruction cache line-fill top level joining request generator, buffer and responder
module icache_fill_top #(
	parameter logic [2:0] CORENO     = 3'd1,
	parameter logic [5:0] CID        = 6'd1,
	parameter logic [5:0] WAIT       = 6'd6,
	parameter int         FIFO_DEPTH = 4,
	parameter int         MEM_LINES  = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	// Miss interface
	input  logic                  hit,
	input  icache_pkg::address_t  miss_adr,
	// Snoop interface
	input  logic                  snoop_v,
	input  icache_pkg::address_t  snoop_adr,
	input  logic [5:0]            snoop_cid,
	// Consumer back-pressure
	input  logic                  fill_hold,
	// Backing store preload
	input  logic                  mem_we,
	input  logic [$clog2(MEM_LINES*icache_pkg::BEATS_PER_LINE)-1:0] mem_idx,
	input  fill_bus_pkg::data_t   mem_wdata,
	// Fill responses
	output logic                  rsp_valid,
	output fill_bus_pkg::tranid_t rsp_tid,
	output icache_pkg::address_t  rsp_adr,
	output fill_bus_pkg::data_t   rsp_data,
	output logic                  rsp_last
);

	import fill_bus_pkg::*;
	import icache_pkg::*;

	// Generator to buffer
	logic     req_valid;
	tranid_t  req_tid;
	address_t req_adr;
	burst_e   req_burst;
	logic     credit_ret;

	// Buffer to responder
	logic     head_valid;
	tranid_t  head_tid;
	address_t head_adr;
	burst_e   head_burst;
	logic     pop;

	icache_req_generator #(
		.CORENO(CORENO), .CID(CID), .WAIT(WAIT), .FIFO_DEPTH(FIFO_DEPTH)
	) u_gen (
		.clk(clk), .rst(rst), .hit(hit), .miss_adr(miss_adr),
		.snoop_v(snoop_v), .snoop_adr(snoop_adr), .snoop_cid(snoop_cid),
		.credit_ret(credit_ret), .req_valid(req_valid), .req_tid(req_tid),
		.req_adr(req_adr), .req_burst(req_burst)
	);

	fill_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk(clk), .rst(rst), .req_valid(req_valid), .req_tid(req_tid),
		.req_adr(req_adr), .req_burst(req_burst), .pop(pop),
		.head_valid(head_valid), .head_tid(head_tid), .head_adr(head_adr),
		.head_burst(head_burst), .credit_ret(credit_ret)
	);

	fill_mem_responder #(.MEM_LINES(MEM_LINES)) u_rsp (
		.clk(clk), .rst(rst), .head_valid(head_valid), .head_tid(head_tid),
		.head_adr(head_adr), .head_burst(head_burst), .fill_hold(fill_hold),
		.mem_we(mem_we), .mem_idx(mem_idx), .mem_wdata(mem_wdata), .pop(pop),
		.rsp_valid(rsp_valid), .rsp_tid(rsp_tid), .rsp_adr(rsp_adr),
		.rsp_data(rsp_data), .rsp_last(rsp_last)
	);

endmodule

// File: design/icache_pkg.sv
// Instruction cache address type and line geometry constants
package icache_pkg;

	// ==============================
	// Addressing
	// ==============================

	// Byte address seen by the fetch unit and the fill bus
	typedef logic [31:0] address_t;

	// ==============================
	// Line geometry
	// ==============================

	// First address bit above the offset within a 64-byte line
	localparam int unsigned ICacheTagLoBit = 6;

	// Top bit of the cache index that snoops compare against
	localparam int unsigned ITAG_BIT = 11;

	// Bytes moved by one fill beat
	localparam int unsigned BEAT_BYTES = 16;

	// A line takes four beats to fill
	localparam int unsigned BEATS_PER_LINE = 4;

endpackage

// File: design/icache_req_generator.sv
// Miss-driven fill request generator with credit counter, snoop abort and LFSR back-off
module icache_req_generator #(
	parameter logic [2:0] CORENO     = 3'd1,
	parameter logic [5:0] CID        = 6'd1,
	parameter logic [5:0] WAIT       = 6'd6,
	parameter int         FIFO_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  hit,
	input  icache_pkg::address_t  miss_adr,
	input  logic                  snoop_v,
	input  icache_pkg::address_t  snoop_adr,
	input  logic [5:0]            snoop_cid,
	input  logic                  credit_ret,
	output logic                  req_valid,
	output fill_bus_pkg::tranid_t req_tid,
	output icache_pkg::address_t  req_adr,
	output fill_bus_pkg::burst_e  req_burst
);

	import fill_bus_pkg::*;
	import icache_pkg::*;

	// Credit counter must be able to hold the full buffer depth
	localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

	typedef enum logic [2:0] {
		RESET_DLY,
		WAIT4MISS,
		BEAT1,
		BEAT2,
		BEAT3,
		RAND_DELAY
	} gen_state_e;

	gen_state_e              state;
	logic [7:0]              dly_cnt;
	logic [5:0]              wait_cnt;
	logic [TID_CNT_BITS-1:0] tid_cnt;
	logic [CRED_W-1:0]       credits;
	logic [16:0]             lfsr;
	logic                    snoop_hit;
	logic                    has_credit;
	logic                    send;
	address_t                line_base;

	// ==============================
	// Beat issue decision
	// ==============================

	// Only the cache index matters for a snoop hit and our own channel is ignored
	assign snoop_hit = snoop_v &&
		(snoop_adr[ITAG_BIT:ICacheTagLoBit] == miss_adr[ITAG_BIT:ICacheTagLoBit]) &&
		(snoop_cid != CID);

	assign has_credit = (credits != '0);

	// A beat leaves when its state allows it and a buffer slot is reserved
	// A snoop hit on the same cycle cancels the beat
	always_comb begin
		send = 1'b0;
		if (!snoop_hit && has_credit) begin
			case (state)
				WAIT4MISS: send = !hit;
				BEAT1, BEAT2, BEAT3: send = 1'b1;
				default: send = 1'b0;
			endcase
		end
	end

	// Miss address with the line offset cleared
	assign line_base = {miss_adr[$bits(address_t)-1:ICacheTagLoBit], {ICacheTagLoBit{1'b0}}};

	// ==============================
	// Credit counter
	// ==============================

	// Counts free buffer slots
	// Taken when a beat is committed so the next cycle already sees the update
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			credits <= CRED_W'(FIFO_DEPTH);
		end else begin
			case ({send, credit_ret})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// ==============================
	// Back-off LFSR
	// ==============================

	// Seventeen-bit maximal length sequence from x^17 + x^14 + 1
	// Held still during the start-up delay so every channel starts from the same seed
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			lfsr <= 17'h1;
		end else if (state != RESET_DLY) begin
			lfsr <= {lfsr[15:0], lfsr[16] ^ lfsr[13]};
		end
	end

	// ==============================
	// Request state machine
	// ==============================

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state     <= RESET_DLY;
			dly_cnt   <= '0;
			wait_cnt  <= '0;
			tid_cnt   <= '0;
			req_valid <= 1'b0;
			req_burst <= CLASSIC;
		end else begin
			// The bus goes idle on any cycle without a beat
			req_valid <= send;
			req_burst <= CLASSIC;
			if (send)
				tid_cnt <= tid_cnt + 1'b1;
			case (state)
				// Channel dependent start-up delay keeps channels on a shared bus apart
				RESET_DLY: begin
					if (dly_cnt == {CID, 2'b00})
						state <= WAIT4MISS;
					dly_cnt <= dly_cnt + 8'd1;
				end
				WAIT4MISS: begin
					if (send) begin
						req_burst <= FIXED;
						state <= BEAT1;
					end
				end
				BEAT1: begin
					if (send) begin
						req_burst <= FIXED;
						state <= BEAT2;
					end
				end
				BEAT2: begin
					if (send) begin
						req_burst <= FIXED;
						state <= BEAT3;
					end
				end
				// Fourth beat closes the line
				BEAT3: begin
					if (send) begin
						req_burst <= EOB;
						wait_cnt <= '0;
						state <= RAND_DELAY;
					end
				end
				// Fixed minimum wait then a random number of extra cycles
				RAND_DELAY: begin
					if (wait_cnt == WAIT && lfsr[2:0] == 3'b111)
						state <= WAIT4MISS;
					else if (wait_cnt != WAIT)
						wait_cnt <= wait_cnt + 6'd1;
				end
				default: state <= RESET_DLY;
			endcase
			// Another channel touching our index abandons the rest of the line
			if (snoop_hit) begin
				wait_cnt <= '0;
				state <= RAND_DELAY;
			end
		end
	end

	// Beat address and id only change when a beat is issued
	// The first beat starts the line and later ones step one beat forward
	always_ff @(posedge clk) begin
		if (send) begin
			if (state == WAIT4MISS)
				req_adr <= line_base;
			else
				req_adr <= req_adr + address_t'(BEAT_BYTES);
			req_tid <= {CORENO, 2'b00, tid_cnt};
		end
	end

endmodule

// File: dv/tb_clk_gen.sv
// Testbench clock source and power-on reset generator
module tb_clk_gen #(
	parameter real PERIOD     = 4.0,
	parameter int  RST_CYCLES = 5
) (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// Reset stays high for a fixed number of rising edges
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: dv/tb_icache_fill.sv
// Line-fill testbench with stimulus, reference model, compare tasks and timeout
module tb_icache_fill;

	timeunit 1ns;
	timeprecision 100ps;

	import fill_bus_pkg::*;
	import icache_pkg::*;

	localparam logic [2:0] CORENO    = 3'd1;
	localparam logic [5:0] CID       = 6'd1;
	localparam int         MEM_LINES = 64;
	localparam int         MEM_BEATS = MEM_LINES * 4;
	localparam int         IDX_W     = $clog2(MEM_BEATS);

	// ==============================
	// Run length budget
	// ==============================

	// Rough cycle lengths of preload, idle check, single miss, streaming, hold and snoops
	localparam int TEST_CYCLES = MEM_BEATS + 60 + 80 + 200 + 150 + 120 + 120;
	localparam int LIMIT       = 4 * TEST_CYCLES + 200;

	typedef struct packed {
		tranid_t  tid;
		address_t adr;
		data_t    data;
		logic     last;
	} beat_t;

	logic             clk, rst, hit, snoop_v, fill_hold, mem_we;
	address_t         miss_adr, snoop_adr;
	logic [5:0]       snoop_cid;
	logic [IDX_W-1:0] mem_idx;
	data_t            mem_wdata;
	logic             rsp_valid, rsp_last;
	tranid_t          rsp_tid;
	address_t         rsp_adr;
	data_t            rsp_data;

	data_t      mem_copy [MEM_BEATS];
	integer     seed = 32'h253db133;
	int         err_count = 0;
	int         cycles = 0;
	int         rsp_count = 0;
	int         line_count = 0;
	int         restarts = 0;
	int         exp_beat = 0;
	logic [2:0] exp_cnt = '0;
	bit         rsp_allowed = 0;
	bit         abort_ok = 0;
	bit         prev_hold = 0;
	address_t   cur_miss = '0;

	tb_clk_gen #(.PERIOD(4.0), .RST_CYCLES(5)) u_clk (.clk(clk), .rst(rst));

	icache_fill_top #(
		.CORENO(CORENO), .CID(CID), .WAIT(6'd6), .FIFO_DEPTH(4), .MEM_LINES(MEM_LINES)
	) DUT (
		.clk(clk), .rst(rst), .hit(hit), .miss_adr(miss_adr),
		.snoop_v(snoop_v), .snoop_adr(snoop_adr), .snoop_cid(snoop_cid),
		.fill_hold(fill_hold), .mem_we(mem_we), .mem_idx(mem_idx), .mem_wdata(mem_wdata),
		.rsp_valid(rsp_valid), .rsp_tid(rsp_tid), .rsp_adr(rsp_adr),
		.rsp_data(rsp_data), .rsp_last(rsp_last)
	);

	// Expected beat from the line rules with an aligned base, 16-byte steps and a core-stamped id
	function automatic beat_t ref_beat(input int beat, input address_t miss,
			input logic [2:0] cnt);
		beat_t b;
		b.adr  = (miss & ~address_t'(63)) + address_t'(16 * beat);
		b.tid  = {CORENO, 1'b0, 1'b0, cnt};
		b.data = mem_copy[(b.adr >> 4) % MEM_BEATS];
		b.last = (beat == 3);
		return b;
	endfunction

	task automatic stop_on_error(input string why);
		err_count++;
		$display("ERROR at %0t: %s", $time, why);
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_tid(input tranid_t got, input tranid_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: rsp_tid got %h expected %h", $time, got, exp);
			stop_on_error("transaction id differs");
		end
	endtask

	task automatic check_adr(input address_t got, input address_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: rsp_adr got %h expected %h", $time, got, exp);
			stop_on_error("beat address differs");
		end
	endtask

	task automatic check_data(input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: rsp_data got %h expected %h", $time, got, exp);
			stop_on_error("beat data differs");
		end
	endtask

	task automatic check_last(input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: rsp_last got %b expected %b", $time, got, exp);
			stop_on_error("last flag differs");
		end
	endtask

	// ==============================
	// Response checker
	// ==============================

	always @(posedge clk) begin
		beat_t e;
		if (rsp_valid) begin
			if (!rsp_allowed)
				stop_on_error("a response appeared while no miss was outstanding");
			// A response issued during the previous held cycle means a beat popped under hold
			if (prev_hold)
				stop_on_error("a beat was popped while fill_hold was high");
			// After an abort the line starts over at beat 0
			e = ref_beat(0, cur_miss, exp_cnt);
			if (abort_ok && exp_beat != 0 && rsp_adr == e.adr) begin
				exp_beat = 0;
				restarts++;
			end
			e = ref_beat(exp_beat, cur_miss, exp_cnt);
			check_tid(rsp_tid, e.tid);
			check_adr(rsp_adr, e.adr);
			check_data(rsp_data, e.data);
			check_last(rsp_last, e.last);
			rsp_count++;
			if (e.last)
				line_count++;
			exp_beat = (exp_beat + 1) % 4;
			exp_cnt  = exp_cnt + 3'd1;
		end
		prev_hold = fill_hold;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: the run went past %0d cycles without finishing", LIMIT);
			$display("Done: errors found");
			$fatal(1, "timeout");
		end
	end

	// Counters are read on the falling edge, away from the checker's updates
	task automatic wait_rsp(input int target);
		while (rsp_count < target)
			@(negedge clk);
	endtask

	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < 40) begin
			@(negedge clk);
			if (rsp_valid)
				quiet = 0;
			else
				quiet++;
		end
		if (exp_beat != 0)
			stop_on_error("responses stopped in the middle of a line");
		rsp_allowed = 0;
	endtask

	task automatic start_miss(input address_t adr);
		@(posedge clk);
		cur_miss    = adr;
		rsp_allowed = 1;
		miss_adr <= adr;
		hit      <= 1'b0;
	endtask

	task automatic preload_store();
		data_t d;
		for (int i = 0; i < MEM_BEATS; i++) begin
			d = {$random(seed), $random(seed), $random(seed), $random(seed)};
			mem_copy[i] = d;
			@(posedge clk);
			mem_we    <= 1'b1;
			mem_idx   <= IDX_W'(i);
			mem_wdata <= d;
		end
		@(posedge clk);
		mem_we <= 1'b0;
	endtask

	// ==============================
	// Stimulus
	// ==============================

	initial begin
		int base;
		int lines;
		int restart_base;
		hit       <= 1'b1;
		miss_adr  <= '0;
		snoop_v   <= 1'b0;
		snoop_adr <= '0;
		snoop_cid <= '0;
		fill_hold <= 1'b0;
		mem_we    <= 1'b0;
		mem_idx   <= '0;
		mem_wdata <= '0;
		@(negedge rst);
		preload_store();
		// Nothing may come back while every fetch hits
		repeat (60) @(posedge clk);

		// One miss gives one line
		base = rsp_count;
		start_miss(32'h0000_1a40);
		wait_rsp(base + 1);
		@(posedge clk);
		hit <= 1'b1;
		wait_quiet();
		if (rsp_count != base + 4)
			stop_on_error("a single miss did not return exactly four beats");

		// Three lines in a row take the id counter through its wrap
		start_miss(32'h0000_0e7c);
		wait_rsp(base + 16);
		@(posedge clk);
		hit <= 1'b1;
		wait_quiet();

		// Hold the consumer once the first beat of a line is out
		base = rsp_count;
		start_miss(32'h0000_2fc8);
		wait_rsp(base + 1);
		@(posedge clk);
		fill_hold <= 1'b1;
		hit       <= 1'b1;
		repeat (40) @(posedge clk);
		fill_hold <= 1'b0;
		wait_quiet();
		if (rsp_count != base + 4)
			stop_on_error("back-pressure lost or added a beat");

		// Another channel snooping the same index two beats into the line
		lines    = line_count;
		base     = restarts;
		abort_ok = 1;
		start_miss(32'h0000_0580);
		@(posedge clk);
		@(posedge clk);
		snoop_v   <= 1'b1;
		snoop_adr <= 32'h0000_05b4;
		snoop_cid <= 6'd5;
		@(posedge clk);
		snoop_v <= 1'b0;
		while (line_count < lines + 1)
			@(negedge clk);
		@(posedge clk);
		hit <= 1'b1;
		wait_quiet();
		if (restarts != base + 1)
			stop_on_error("the snoop did not restart the line from beat 0");

		// Own channel id and a foreign index leave the line alone
		base         = rsp_count;
		restart_base = restarts;
		start_miss(32'h0000_0c3f);
		// Both snoops land while beats of the line are still being sent
		@(posedge clk);
		snoop_v   <= 1'b1;
		snoop_adr <= 32'h0000_0c00;
		snoop_cid <= CID;
		@(posedge clk);
		snoop_adr <= 32'h0000_0c40;
		snoop_cid <= 6'd5;
		@(posedge clk);
		snoop_v <= 1'b0;
		wait_rsp(base + 1);
		@(posedge clk);
		hit <= 1'b1;
		wait_quiet();
		if (rsp_count != base + 4 || restarts != restart_base)
			stop_on_error("a non-matching snoop disturbed the line");
		abort_ok = 0;

		if (err_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
